// File: hw/raster_pkg.sv
package raster_pkg;

    // ====================
    // numeric and index types
    // ====================

    // q16.16 signed
    typedef logic signed [31:0] q16_16_t;

    // vertex or triangle index, also counts
    typedef logic [15:0] vidx_t;

    typedef struct packed {
        q16_16_t x, y, z;
    } vertex_t;

    // indices relative to the instance vert_base
    typedef struct packed {
        vidx_t i0, i1, i2;
    } tri_idx_t;

    typedef struct packed {
        vidx_t vert_base;
        vidx_t tri_base;
        vidx_t tri_count;
    } inst_hdr_t;

    // one output axis is m0*x + m1*y + m2*z + m3
    typedef struct packed {
        q16_16_t m0, m1, m2, m3;
    } xform_row_t;

    // [0] gives world x, [1] world y, [2] world z
    typedef xform_row_t [2:0] transform_t;

    // ====================
    // loader word
    // ====================

    typedef enum logic [1:0] {
        LOAD_VERTEX,
        LOAD_TRIANGLE,
        LOAD_INST_HDR,
        LOAD_INST_ROW
    } load_kind_e;

    // 128-bit host word, payload in the low bits
    typedef union packed {
        struct packed {
            logic [31:0] pad;
            vertex_t     vtx;
        } vtx_view;
        struct packed {
            logic [79:0] pad;
            tri_idx_t    idx;
        } tri_view;
        struct packed {
            logic [79:0] pad;
            inst_hdr_t   hdr;
        } hdr_view;
        xform_row_t row_view;
    } load_word_u;

    // ====================
    // pipeline payloads
    // ====================

    typedef struct packed {
        vidx_t   inst_id;
        vidx_t   tri_num;
        vertex_t v0, v1, v2;
    } world_tri_t;

    // model-space triangle plus its instance transform
    typedef struct packed {
        vidx_t      inst_id;
        vidx_t      tri_num;
        vertex_t    v0, v1, v2;
        transform_t xform;
    } setup_tri_t;

endpackage

// File: hw/raster_ifs.sv
`timescale 1ns/1ps

// scene read port, data comes back one cycle after the address
interface scene_rd_if;
    // absolute addresses
    raster_pkg::vidx_t      inst_addr;
    raster_pkg::vidx_t      tri_addr;
    raster_pkg::vidx_t      vert_addr;
    // registered read data
    raster_pkg::inst_hdr_t  hdr;
    raster_pkg::transform_t xform;
    raster_pkg::tri_idx_t   tri_idx;
    raster_pkg::vertex_t    vert;

    modport drv (
        output inst_addr, tri_addr, vert_addr,
        input  hdr, xform, tri_idx, vert
    );

    modport mem (
        input  inst_addr, tri_addr, vert_addr,
        output hdr, xform, tri_idx, vert
    );
endinterface

// setup triangle stream, valid/ready
interface tri_setup_if;
    logic                   valid;
    logic                   ready;
    raster_pkg::setup_tri_t setup;

    modport src (output valid, setup, input ready);

    modport snk (input valid, setup, output ready);
endinterface

// File: hw/scene_mem.sv
`timescale 1ns/1ps

module scene_mem #(
    parameter int MAX_VERT = 256,
    parameter int MAX_TRI  = 256,
    parameter int MAX_INST = 16
) (
    input  logic                   clk_render,
    input  logic                   reset,
    input  logic                   load_valid,
    output logic                   load_ready,
    input  raster_pkg::load_kind_e load_kind,
    input  logic [15:0]            load_addr,
    input  raster_pkg::load_word_u load_word,
    input  logic                   draw_busy,
    scene_rd_if.mem                rd
);

    localparam int VERT_AW = $clog2(MAX_VERT);
    localparam int TRI_AW  = $clog2(MAX_TRI);
    localparam int INST_AW = $clog2(MAX_INST);

    // ====================
    // storage
    // ====================

    raster_pkg::vertex_t    vert_mem  [MAX_VERT];
    raster_pkg::tri_idx_t   tri_mem   [MAX_TRI];
    raster_pkg::inst_hdr_t  hdr_mem   [MAX_INST];
    raster_pkg::transform_t xform_mem [MAX_INST];

    logic        load_fire;
    // row load address split into instance and row
    logic [15:0] row_inst;
    logic [1:0]  row_sel;
    // depth of the array picked by load_kind
    logic [16:0] load_limit;

    // loads stall for the whole draw
    assign load_ready = !draw_busy;
    assign load_fire  = load_valid && load_ready;

    // address is inst * 3 + row
    assign row_inst = load_addr / 16'd3;
    assign row_sel  = 2'(load_addr % 16'd3);

    always_comb begin
        case (load_kind)
            raster_pkg::LOAD_VERTEX:   load_limit = 17'(MAX_VERT);
            raster_pkg::LOAD_TRIANGLE: load_limit = 17'(MAX_TRI);
            raster_pkg::LOAD_INST_HDR: load_limit = 17'(MAX_INST);
            default:                   load_limit = 17'(MAX_INST * 3);
        endcase
    end

    // ====================
    // load write port
    // ====================

    always_ff @(posedge clk_render) begin
        if (load_fire) begin
            case (load_kind)
                raster_pkg::LOAD_VERTEX:
                    vert_mem[load_addr[VERT_AW-1:0]] <= load_word.vtx_view.vtx;
                raster_pkg::LOAD_TRIANGLE:
                    tri_mem[load_addr[TRI_AW-1:0]] <= load_word.tri_view.idx;
                raster_pkg::LOAD_INST_HDR:
                    hdr_mem[load_addr[INST_AW-1:0]] <= load_word.hdr_view.hdr;
                default:
                    // one row of the 3x4 matrix per word
                    xform_mem[row_inst[INST_AW-1:0]][row_sel] <= load_word.row_view;
            endcase
        end
    end

    // ====================
    // registered reads
    // ====================

    // header and transform share the instance address
    always_ff @(posedge clk_render) begin
        rd.hdr     <= hdr_mem[rd.inst_addr[INST_AW-1:0]];
        rd.xform   <= xform_mem[rd.inst_addr[INST_AW-1:0]];
        rd.tri_idx <= tri_mem[rd.tri_addr[TRI_AW-1:0]];
        rd.vert    <= vert_mem[rd.vert_addr[VERT_AW-1:0]];
    end

    // host must stay inside the selected array
    load_in_range: assert property (@(posedge clk_render) disable iff (reset)
        load_fire |-> ({1'b0, load_addr} < load_limit));

endmodule

// File: hw/frame_driver.sv
`timescale 1ns/1ps

module frame_driver #(
    parameter int MAX_INST = 16,
    parameter int MAX_TRI  = 256
) (
    input  logic                      clk_render,
    input  logic                      reset,
    input  logic                      draw_start,
    input  logic [$clog2(MAX_INST):0] draw_inst_count,
    output logic                      busy,
    output logic                      draw_done,
    scene_rd_if.drv                   rd,
    tri_setup_if.src                  setup
);

    localparam int INST_CW = $clog2(MAX_INST) + 1;
    localparam int TRI_CW  = $clog2(MAX_TRI) + 1;

    // fsm encoding
    localparam logic [2:0] IDLE    = 3'd0;
    localparam logic [2:0] HDR     = 3'd1;
    localparam logic [2:0] TRI_IDX = 3'd2;
    localparam logic [2:0] VERT0   = 3'd3;
    localparam logic [2:0] VERT1   = 3'd4;
    localparam logic [2:0] VERT2   = 3'd5;
    localparam logic [2:0] PRESENT = 3'd6;

    logic [2:0]             state;
    logic [INST_CW-1:0]     inst_num;
    logic [INST_CW-1:0]     inst_total;
    // triangle number within the instance
    logic [TRI_CW-1:0]      tri_num;
    logic                   setup_valid;
    raster_pkg::setup_tri_t setup_r;
    raster_pkg::vidx_t      tri_next;
    raster_pkg::vidx_t      vert_rel;

    assign busy = (state != IDLE);

    // ====================
    // read addresses
    // ====================

    // rd.hdr stays valid for the whole instance, inst_addr is held
    assign rd.inst_addr = raster_pkg::vidx_t'(inst_num);
    assign rd.tri_addr  = rd.hdr.tri_base + raster_pkg::vidx_t'(tri_num);

    // one vertex address per VERTn state
    always_comb begin
        case (state)
            VERT0:   vert_rel = rd.tri_idx.i0;
            VERT1:   vert_rel = rd.tri_idx.i1;
            default: vert_rel = rd.tri_idx.i2;
        endcase
    end
    assign rd.vert_addr = rd.hdr.vert_base + vert_rel;

    assign tri_next = raster_pkg::vidx_t'(tri_num) + 16'd1;

    // ====================
    // sequencer
    // ====================

    always_ff @(posedge clk_render) begin
        if (reset) begin
            state       <= IDLE;
            inst_num    <= '0;
            inst_total  <= '0;
            tri_num     <= '0;
            setup_valid <= 1'b0;
            draw_done   <= 1'b0;
        end else begin
            draw_done <= 1'b0;
            case (state)
                IDLE: begin
                    if (draw_start) begin
                        inst_num   <= '0;
                        inst_total <= draw_inst_count;
                        state      <= HDR;
                    end
                end
                HDR: begin
                    tri_num <= '0;
                    // all instances walked
                    if (inst_num == inst_total) begin
                        draw_done <= 1'b1;
                        state     <= IDLE;
                    end else begin
                        state <= TRI_IDX;
                    end
                end
                TRI_IDX: begin
                    // empty instance, skip it
                    if (rd.hdr.tri_count == '0) begin
                        inst_num <= inst_num + 1'b1;
                        state    <= HDR;
                    end else begin
                        state <= VERT0;
                    end
                end
                VERT0: state <= VERT1;
                VERT1: state <= VERT2;
                VERT2: state <= PRESENT;
                default: begin
                    // first PRESENT cycle captures v2, then raise valid
                    if (!setup_valid) begin
                        setup_valid <= 1'b1;
                    end else if (setup.ready) begin
                        setup_valid <= 1'b0;
                        if (tri_next == rd.hdr.tri_count) begin
                            inst_num <= inst_num + 1'b1;
                            state    <= HDR;
                        end else begin
                            tri_num <= tri_num + 1'b1;
                            state   <= TRI_IDX;
                        end
                    end
                end
            endcase
        end
    end

    // setup payload capture
    always_ff @(posedge clk_render) begin
        case (state)
            TRI_IDX: begin
                setup_r.inst_id <= raster_pkg::vidx_t'(inst_num);
                setup_r.tri_num <= raster_pkg::vidx_t'(tri_num);
                setup_r.xform   <= rd.xform;
            end
            VERT1: setup_r.v0 <= rd.vert;
            VERT2: setup_r.v1 <= rd.vert;
            PRESENT: begin
                if (!setup_valid) begin
                    setup_r.v2 <= rd.vert;
                end
            end
        endcase
    end

    assign setup.valid = setup_valid;
    assign setup.setup = setup_r;

    // the host waits for draw_done before a new frame
    no_restart: assert property (@(posedge clk_render) disable iff (reset)
        draw_start |-> !busy);

endmodule

// File: hw/model_world_xform.sv
`timescale 1ns/1ps

module model_world_xform (
    input  logic                   clk_render,
    input  logic                   reset,
    input  logic                   out_ready,
    output logic                   out_valid,
    output raster_pkg::world_tri_t out_tri,
    tri_setup_if.snk               setup
);

    // compute slot
    logic                   calc_active;
    logic [1:0]             vtx_sel;
    raster_pkg::setup_tri_t calc_in;
    raster_pkg::vertex_t    part_v0;
    raster_pkg::vertex_t    part_v1;
    raster_pkg::vertex_t    cur_vtx;
    raster_pkg::vertex_t    cur_world;
    // result slot
    logic                   res_valid;
    raster_pkg::world_tri_t res_tri;
    // handshake helpers
    logic                   res_free;
    logic                   calc_last;
    logic                   calc_done;
    logic                   accept;

    // ====================
    // fixed-point math
    // ====================

    // products at 64 bits, >>> 16 each, sum cut to 32
    function automatic raster_pkg::q16_16_t xform_axis(
        input raster_pkg::xform_row_t row,
        input raster_pkg::vertex_t    v
    );
        logic signed [63:0] px;
        logic signed [63:0] py;
        logic signed [63:0] pz;
        logic signed [63:0] sum;
        px  = 64'($signed(row.m0)) * 64'($signed(v.x));
        py  = 64'($signed(row.m1)) * 64'($signed(v.y));
        pz  = 64'($signed(row.m2)) * 64'($signed(v.z));
        sum = (px >>> 16) + (py >>> 16) + (pz >>> 16) + 64'($signed(row.m3));
        return sum[31:0];
    endfunction

    function automatic raster_pkg::vertex_t xform_vertex(
        input raster_pkg::transform_t xf,
        input raster_pkg::vertex_t    v
    );
        raster_pkg::vertex_t r;
        r.x = xform_axis(xf[0], v);
        r.y = xform_axis(xf[1], v);
        r.z = xform_axis(xf[2], v);
        return r;
    endfunction

    // one vertex per cycle through the 9 multipliers
    always_comb begin
        case (vtx_sel)
            2'd0:    cur_vtx = calc_in.v0;
            2'd1:    cur_vtx = calc_in.v1;
            default: cur_vtx = calc_in.v2;
        endcase
        cur_world = xform_vertex(calc_in.xform, cur_vtx);
    end

    // ====================
    // handshake
    // ====================

    assign res_free  = !res_valid || out_ready;
    assign calc_last = calc_active && (vtx_sel == 2'd2);
    // last vertex stalls while the result slot is full
    assign calc_done = calc_last && res_free;
    // a new triangle may enter as the current one retires
    assign setup.ready = res_free && (!calc_active || calc_last);
    assign accept      = setup.valid && setup.ready;

    always_ff @(posedge clk_render) begin
        if (reset) begin
            calc_active <= 1'b0;
            vtx_sel     <= 2'd0;
            res_valid   <= 1'b0;
        end else begin
            if (accept) begin
                calc_active <= 1'b1;
                vtx_sel     <= 2'd0;
            end else if (calc_done) begin
                calc_active <= 1'b0;
                vtx_sel     <= 2'd0;
            end else if (calc_active && !calc_last) begin
                vtx_sel <= vtx_sel + 2'd1;
            end
            if (calc_done) begin
                res_valid <= 1'b1;
            end else if (out_ready) begin
                res_valid <= 1'b0;
            end
        end
    end

    // payload, no reset
    always_ff @(posedge clk_render) begin
        if (accept) begin
            calc_in <= setup.setup;
        end
        if (calc_active && vtx_sel == 2'd0) begin
            part_v0 <= cur_world;
        end
        if (calc_active && vtx_sel == 2'd1) begin
            part_v1 <= cur_world;
        end
        if (calc_done) begin
            res_tri.inst_id <= calc_in.inst_id;
            res_tri.tri_num <= calc_in.tri_num;
            res_tri.v0      <= part_v0;
            res_tri.v1      <= part_v1;
            res_tri.v2      <= cur_world;
        end
    end

    assign out_valid = res_valid;
    assign out_tri   = res_tri;

    // stalled result must not move
    out_hold: assert property (@(posedge clk_render) disable iff (reset)
        out_valid && !out_ready |=> out_valid && $stable(out_tri));

endmodule

// File: hw/top_raster_system.sv
`timescale 1ns/1ps

module top_raster_system #(
    parameter int MAX_VERT = 256,
    parameter int MAX_TRI  = 256,
    parameter int MAX_INST = 16
) (
    input  logic                      clk_render,
    input  logic                      reset,
    // ====================
    // scene loader
    input  logic                      load_valid,
    output logic                      load_ready,
    input  raster_pkg::load_kind_e    load_kind,
    input  logic [15:0]               load_addr,
    input  raster_pkg::load_word_u    load_word,
    // draw control
    input  logic                      draw_start,
    input  logic [$clog2(MAX_INST):0] draw_inst_count,
    output logic                      busy,
    output logic                      draw_done,
    // world-space triangles out
    output logic                      out_valid,
    input  logic                      out_ready,
    output raster_pkg::world_tri_t    out_tri
);

    // memory to driver
    scene_rd_if  rd_bus ();
    // driver to transformer
    tri_setup_if setup_bus ();

    scene_mem #(
        .MAX_VERT (MAX_VERT),
        .MAX_TRI  (MAX_TRI),
        .MAX_INST (MAX_INST)
    ) u_scene_mem (
        .clk_render (clk_render),
        .reset      (reset),
        .load_valid (load_valid),
        .load_ready (load_ready),
        .load_kind  (load_kind),
        .load_addr  (load_addr),
        .load_word  (load_word),
        // busy doubles as the load stall
        .draw_busy  (busy),
        .rd         (rd_bus.mem)
    );

    frame_driver #(
        .MAX_INST (MAX_INST),
        .MAX_TRI  (MAX_TRI)
    ) u_frame_driver (
        .clk_render      (clk_render),
        .reset           (reset),
        .draw_start      (draw_start),
        .draw_inst_count (draw_inst_count),
        .busy            (busy),
        .draw_done       (draw_done),
        .rd              (rd_bus.drv),
        .setup           (setup_bus.src)
    );

    model_world_xform u_model_world_xform (
        .clk_render (clk_render),
        .reset      (reset),
        .out_ready  (out_ready),
        .out_valid  (out_valid),
        .out_tri    (out_tri),
        .setup      (setup_bus.snk)
    );

endmodule

// File: tests/tb_scene_model.svh
`ifndef TB_SCENE_MODEL_SVH
`define TB_SCENE_MODEL_SVH

// ====================
// scene copy
// ====================

localparam int NV = 16;
localparam int NT = 6;
localparam int NI = 4;
// vertices, triangles, headers, then three rows per instance
localparam int LOAD_WORDS = NV + NT + NI + 3 * NI;

localparam raster_pkg::q16_16_t Q_ONE = 32'sh0001_0000;
localparam raster_pkg::q16_16_t Q_ZERO = 32'sh0000_0000;

raster_pkg::vertex_t    m_vert [NV];
raster_pkg::tri_idx_t   m_tri  [NT];
raster_pkg::inst_hdr_t  m_hdr  [NI];
raster_pkg::transform_t m_xf   [NI];

// expected outputs in walk order
raster_pkg::world_tri_t exp_q [$];

logic [15:0] lfsr_state = 16'd35;

// ====================
// random source
// ====================

// fibonacci, taps 16 14 13 11, one step per bit
function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
        fb         = ^(lfsr_state & 16'hB400);
        lfsr_state = {lfsr_state[14:0], fb};
        r          = {r[30:0], fb};
    end
    return r;
endfunction

// sign extended n-bit value read as q16.16
function automatic raster_pkg::q16_16_t rand_q(input int nbits);
    logic signed [31:0] r;
    r = rand_bits(nbits) << (32 - nbits);
    return r >>> (32 - nbits);
endfunction

function automatic raster_pkg::xform_row_t make_row(
    input raster_pkg::q16_16_t a,
    input raster_pkg::q16_16_t b,
    input raster_pkg::q16_16_t c,
    input raster_pkg::q16_16_t d
);
    raster_pkg::xform_row_t r;
    r.m0 = a;
    r.m1 = b;
    r.m2 = c;
    r.m3 = d;
    return r;
endfunction

function automatic void build_scene();
    for (int i = 0; i < NV; i++) begin
        m_vert[i].x = rand_q(24);
        m_vert[i].y = rand_q(24);
        m_vert[i].z = rand_q(24);
    end
    // relative indices 0..7
    for (int i = 0; i < NT; i++) begin
        m_tri[i].i0 = raster_pkg::vidx_t'(rand_bits(3));
        m_tri[i].i1 = raster_pkg::vidx_t'(rand_bits(3));
        m_tri[i].i2 = raster_pkg::vidx_t'(rand_bits(3));
    end
    // instances share triangles at shifted bases, inst 2 is empty
    m_hdr[0] = '{vert_base: 16'd0, tri_base: 16'd0, tri_count: 16'd4};
    m_hdr[1] = '{vert_base: 16'd8, tri_base: 16'd2, tri_count: 16'd3};
    m_hdr[2] = '{vert_base: 16'd4, tri_base: 16'd0, tri_count: 16'd0};
    m_hdr[3] = '{vert_base: 16'd2, tri_base: 16'd1, tri_count: 16'd5};
    m_xf[0][0] = make_row(Q_ONE, Q_ZERO, Q_ZERO, Q_ZERO);
    m_xf[0][1] = make_row(Q_ZERO, Q_ONE, Q_ZERO, Q_ZERO);
    m_xf[0][2] = make_row(Q_ZERO, Q_ZERO, Q_ONE, Q_ZERO);
    // 0.5 -1.25 0 3.0 / -1 0 0.75 -2.5 / 0.25 0.125 -0.375 0
    m_xf[1][0] = make_row(32'sh0000_8000, -32'sh0001_4000, Q_ZERO, 32'sh0003_0000);
    m_xf[1][1] = make_row(-32'sh0001_0000, Q_ZERO, 32'sh0000_C000, -32'sh0002_8000);
    m_xf[1][2] = make_row(32'sh0000_4000, 32'sh0000_2000, -32'sh0000_6000, Q_ZERO);
    for (int i = 2; i < NI; i++) begin
        for (int r = 0; r < 3; r++) begin
            m_xf[i][r] = make_row(rand_q(20), rand_q(20), rand_q(20), rand_q(24));
        end
    end
endfunction

// ====================
// reference transform
// ====================

// each product at 64 bits >>> 16, sum cut to 32 bits
function automatic raster_pkg::q16_16_t ref_axis(
    input raster_pkg::xform_row_t r,
    input raster_pkg::vertex_t    v
);
    longint acc;
    acc = ((longint'(r.m0) * longint'(v.x)) >>> 16)
        + ((longint'(r.m1) * longint'(v.y)) >>> 16)
        + ((longint'(r.m2) * longint'(v.z)) >>> 16)
        + longint'(r.m3);
    return raster_pkg::q16_16_t'(acc);
endfunction

function automatic raster_pkg::vertex_t ref_vertex(
    input raster_pkg::transform_t xf,
    input raster_pkg::vertex_t    v
);
    raster_pkg::vertex_t w;
    w.x = ref_axis(xf[0], v);
    w.y = ref_axis(xf[1], v);
    w.z = ref_axis(xf[2], v);
    return w;
endfunction

// triangle t of instance inst, t counted within the instance
function automatic raster_pkg::world_tri_t ref_tri(input int inst, input int t);
    raster_pkg::inst_hdr_t  h;
    raster_pkg::tri_idx_t   ix;
    raster_pkg::world_tri_t w;
    int                     vb;
    h  = m_hdr[inst];
    ix = m_tri[int'(h.tri_base) + t];
    vb = int'(h.vert_base);
    w.inst_id = raster_pkg::vidx_t'(inst);
    w.tri_num = raster_pkg::vidx_t'(t);
    w.v0 = ref_vertex(m_xf[inst], m_vert[vb + int'(ix.i0)]);
    w.v1 = ref_vertex(m_xf[inst], m_vert[vb + int'(ix.i1)]);
    w.v2 = ref_vertex(m_xf[inst], m_vert[vb + int'(ix.i2)]);
    return w;
endfunction

// push one draw of n instances in walk order
function automatic void expect_draw(input int n);
    for (int i = 0; i < n; i++) begin
        for (int t = 0; t < int'(m_hdr[i].tri_count); t++) begin
            exp_q.push_back(ref_tri(i, t));
        end
    end
endfunction

function automatic int count_tris(input int n);
    int c;
    c = 0;
    for (int i = 0; i < n; i++) begin
        c = c + int'(m_hdr[i].tri_count);
    end
    return c;
endfunction

`endif

// File: tests/tb_raster_system.sv
`timescale 1ns/1ps

module tb_raster_system;

    logic                   clk_render = 1'b0;
    logic                   reset;
    logic                   load_valid;
    logic                   load_ready;
    raster_pkg::load_kind_e load_kind;
    logic [15:0]            load_addr;
    raster_pkg::load_word_u load_word;
    logic                   draw_start;
    logic [4:0]             draw_inst_count;
    logic                   busy;
    logic                   draw_done;
    logic                   out_valid;
    logic                   out_ready;
    raster_pkg::world_tri_t out_tri;

    // identity, back-pressure with a load poke, repeat, empty
    localparam int DRAW_N [4] = '{1, 4, 4, 0};

    int                     err_value    = 0;
    int                     err_proto    = 0;
    int                     cycles       = 0;
    int                     cycle_limit  = 1000;
    int                     exp_rd       = 0;
    int                     exp_left     = 0;
    logic                   done_in_draw = 1'b0;
    raster_pkg::world_tri_t exp_head;

    `include "tb_scene_model.svh"

    top_raster_system u_dut (
        .clk_render      (clk_render),
        .reset           (reset),
        .load_valid      (load_valid),
        .load_ready      (load_ready),
        .load_kind       (load_kind),
        .load_addr       (load_addr),
        .load_word       (load_word),
        .draw_start      (draw_start),
        .draw_inst_count (draw_inst_count),
        .busy            (busy),
        .draw_done       (draw_done),
        .out_valid       (out_valid),
        .out_ready       (out_ready),
        .out_tri         (out_tri)
    );

    always #50 clk_render = ~clk_render;

    // ====================
    // scoreboard and bookkeeping
    // ====================

    // head and count registered, assertions see them before the pop
    always @(posedge clk_render) begin
        int next_rd;
        next_rd = exp_rd;
        if (out_valid && out_ready && exp_rd < exp_q.size()) begin
            next_rd = exp_rd + 1;
        end
        exp_rd   <= next_rd;
        exp_left <= exp_q.size() - next_rd;
        if (next_rd < exp_q.size()) begin
            exp_head <= exp_q[next_rd];
        end
    end

    // one draw_done per draw
    always @(posedge clk_render) begin
        if (draw_start) begin
            done_in_draw <= 1'b0;
        end else if (draw_done) begin
            done_in_draw <= 1'b1;
        end
    end

    always @(posedge clk_render) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("run timed out after %0d cycles", cycles);
            $display("errors: value %0d, protocol %0d", err_value, err_proto);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    // ====================
    // checks
    // ====================

    reset_state: assert property (@(posedge clk_render)
        $fell(reset) |-> !out_valid && !busy && !draw_done && load_ready)
        else begin
            err_proto = err_proto + 1;
            $display("outputs were not in their reset state when reset was released");
        end

    no_extra: assert property (@(posedge clk_render) disable iff (reset)
        out_valid && out_ready |-> exp_left != 0)
        else begin
            err_proto = err_proto + 1;
            $display("a triangle came out that was not expected at %0t", $time);
        end

    out_matches: assert property (@(posedge clk_render) disable iff (reset)
        out_valid && out_ready && exp_left != 0 |-> out_tri == exp_head)
        else begin
            err_value = err_value + 1;
            $display("error %0t: got inst %0d tri %0d, expected inst %0d tri %0d",
                $time, out_tri.inst_id, out_tri.tri_num, exp_head.inst_id, exp_head.tri_num);
        end

    out_steady: assert property (@(posedge clk_render) disable iff (reset)
        out_valid && !out_ready |=> out_valid && $stable(out_tri))
        else begin
            err_proto = err_proto + 1;
            $display("stalled output changed or dropped at %0t", $time);
        end

    load_follows_busy: assert property (@(posedge clk_render) disable iff (reset)
        load_ready != busy)
        else begin
            err_proto = err_proto + 1;
            $display("load_ready did not track the draw state at %0t", $time);
        end

    load_refused: assert property (@(posedge clk_render) disable iff (reset)
        load_valid && busy |-> !load_ready)
        else begin
            err_proto = err_proto + 1;
            $display("a load was accepted during a draw at %0t", $time);
        end

    busy_after_start: assert property (@(posedge clk_render) disable iff (reset)
        draw_start |=> busy)
        else begin
            err_proto = err_proto + 1;
            $display("busy did not rise the cycle after draw_start");
        end

    done_once: assert property (@(posedge clk_render) disable iff (reset)
        draw_done |-> !done_in_draw && !busy)
        else begin
            err_proto = err_proto + 1;
            $display("draw_done repeated in one draw or came while busy");
        end

    // at most one computing and one waiting behind the last setup
    done_after_last: assert property (@(posedge clk_render) disable iff (reset)
        draw_done |-> exp_left <= 2)
        else begin
            err_proto = err_proto + 1;
            $display("draw_done came before the last triangle was taken");
        end

    empty_draw: assert property (@(posedge clk_render) disable iff (reset)
        $rose(busy) && draw_inst_count == 5'd0 |=> draw_done)
        else begin
            err_proto = err_proto + 1;
            $display("an empty draw did not finish on the next cycle");
        end

    // ====================
    // stimulus
    // ====================

    task automatic step();
        @(posedge clk_render);
        #1;
    endtask

    task automatic load_one(
        input raster_pkg::load_kind_e kind,
        input logic [15:0]            addr,
        input raster_pkg::load_word_u word
    );
        load_valid = 1'b1;
        load_kind  = kind;
        load_addr  = addr;
        load_word  = word;
        while (!load_ready) begin
            step();
        end
        step();
    endtask

    task automatic load_scene();
        raster_pkg::load_word_u w;
        for (int i = 0; i < NV; i++) begin
            w = '0;
            w.vtx_view.vtx = m_vert[i];
            load_one(raster_pkg::LOAD_VERTEX, 16'(i), w);
        end
        for (int i = 0; i < NT; i++) begin
            w = '0;
            w.tri_view.idx = m_tri[i];
            load_one(raster_pkg::LOAD_TRIANGLE, 16'(i), w);
        end
        for (int i = 0; i < NI; i++) begin
            w = '0;
            w.hdr_view.hdr = m_hdr[i];
            load_one(raster_pkg::LOAD_INST_HDR, 16'(i), w);
            // rows at inst * 3 + row
            for (int r = 0; r < 3; r++) begin
                w.row_view = m_xf[i][r];
                load_one(raster_pkg::LOAD_INST_ROW, 16'(i * 3 + r), w);
            end
        end
        load_valid = 1'b0;
    endtask

    // stall drives out_ready from the lfsr, poke tries a vertex load mid-draw
    task automatic run_draw(input int n, input bit stall, input bit poke);
        expect_draw(n);
        draw_inst_count = 5'(n);
        draw_start      = 1'b1;
        step();
        draw_start = 1'b0;
        if (poke) begin
            // first vertex of instance 0 triangle 0
            load_valid = 1'b1;
            load_kind  = raster_pkg::LOAD_VERTEX;
            load_addr  = m_hdr[0].vert_base + m_tri[m_hdr[0].tri_base].i0;
            load_word  = '1;
        end
        while (!draw_done) begin
            out_ready = stall ? (rand_bits(1) == 32'd1) : 1'b1;
            step();
        end
        // busy just fell, drop the poke before the next edge
        load_valid = 1'b0;
        while (exp_left != 0) begin
            out_ready = stall ? (rand_bits(1) == 32'd1) : 1'b1;
            step();
        end
        out_ready = 1'b1;
        repeat (6) step();
    endtask

    initial begin
        reset           = 1'b1;
        load_valid      = 1'b0;
        load_kind       = raster_pkg::LOAD_VERTEX;
        load_addr       = 16'd0;
        load_word       = '0;
        draw_start      = 1'b0;
        draw_inst_count = 5'd0;
        out_ready       = 1'b1;
        build_scene();
        cycle_limit = 20 * (count_tris(DRAW_N[0]) + count_tris(DRAW_N[1])
            + count_tris(DRAW_N[2]) + count_tris(DRAW_N[3])) + LOAD_WORDS + 200;
        repeat (16) @(posedge clk_render);
        #1;
        reset = 1'b0;
        step();
        load_scene();
        run_draw(DRAW_N[0], 1'b0, 1'b0);
        run_draw(DRAW_N[1], 1'b1, 1'b1);
        // same frame again over the poked vertex
        run_draw(DRAW_N[2], 1'b0, 1'b0);
        run_draw(DRAW_N[3], 1'b0, 1'b0);
        $display("errors: value %0d, protocol %0d", err_value, err_proto);
        if (err_value + err_proto == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// File: src.f
+incdir+tests
hw/raster_pkg.sv
hw/raster_ifs.sv
hw/scene_mem.sv
hw/frame_driver.sv
hw/model_world_xform.sv
hw/top_raster_system.sv
tests/tb_raster_system.sv

// File: Makefile
# Verilator build and run of the raster back end testbench

VERILATOR ?= verilator
TOP       ?= tb_raster_system
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(wildcard hw/*.sv) $(wildcard tests/*.sv) $(wildcard tests/*.svh)
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)
	@! grep -q "STATUS: FAIL" $(LOG)
	@grep -q "STATUS: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
